// File: common/isa_pkg.sv
// isa_pkg
// rv32 datapath widths and the funct3 encodings of loads and stores
package isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_we_w   = 4;
    localparam int funct3_w   = 3;

    // load funct3
    localparam logic [funct3_w-1:0] f3_lb  = 3'b000;
    localparam logic [funct3_w-1:0] f3_lh  = 3'b001;
    localparam logic [funct3_w-1:0] f3_lw  = 3'b010;
    localparam logic [funct3_w-1:0] f3_lbu = 3'b100;
    localparam logic [funct3_w-1:0] f3_lhu = 3'b101;

    // store funct3
    localparam logic [funct3_w-1:0] f3_sb  = 3'b000;
    localparam logic [funct3_w-1:0] f3_sh  = 3'b001;
    localparam logic [funct3_w-1:0] f3_sw  = 3'b010;

endpackage

// File: common/mem_pkg.sv
// mem_pkg
// data memory geometry, read latency, memory stage states and the
// byte/half/word view of one memory word
package mem_pkg;

    import isa_pkg::*;

    localparam int mem_words    = 256;
    localparam int mem_addr_w   = 8;         // log2 of mem_words
    localparam int sram_latency = 2;         // rd_en to rvalid
    localparam int strb_w       = xlen / 8;  // byte lanes per word

    // memory stage states
    localparam logic [1:0] st_idle      = 2'd0;
    localparam logic [1:0] st_issue     = 2'd1;
    localparam logic [1:0] st_wait_read = 2'd2;
    localparam logic [1:0] st_full      = 2'd3;

    typedef union packed {
        logic [xlen-1:0]                word;
        logic [strb_w/2-1:0][15:0]      half;
        logic [strb_w-1:0][7:0]         bytes;
    } mem_word_u;

endpackage

// File: mem_stage/mem_align.sv
`timescale 1ns/100ps
// mem_align
// load lane select with sign/zero extension, store lane replication and strobes
module mem_align import isa_pkg::*, mem_pkg::*; (
    input  logic [funct3_w-1:0] funct3,
    input  logic [1:0]          byte_off,
    input  logic [xlen-1:0]     rdata,
    input  logic [xlen-1:0]     store_data,
    output logic [xlen-1:0]     load_data,
    output logic [xlen-1:0]     wdata,
    output logic [strb_w-1:0]   wstrb
);

    mem_word_u   rd_u;
    mem_word_u   wr_u;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign rd_u     = rdata;
    assign sel_byte = rd_u.bytes[byte_off];
    assign sel_half = rd_u.half[byte_off[1]];  // bit 0 ignored
    assign wdata    = wr_u.word;

    always_comb begin
        case (funct3)
            f3_lb:   load_data = {{(xlen-8){sel_byte[7]}}, sel_byte};
            f3_lh:   load_data = {{(xlen-16){sel_half[15]}}, sel_half};
            f3_lbu:  load_data = {{(xlen-8){1'b0}}, sel_byte};
            f3_lhu:  load_data = {{(xlen-16){1'b0}}, sel_half};
            default: load_data = rd_u.word;  // lw
        endcase
    end

    always_comb begin
        wr_u.word = store_data;
        wstrb     = '0;
        case (funct3)
            f3_sb: begin
                for (int i = 0; i < strb_w; i++)
                    wr_u.bytes[i] = store_data[7:0];
                wstrb[byte_off] = 1'b1;
            end
            f3_sh: begin
                for (int i = 0; i < strb_w / 2; i++)
                    wr_u.half[i] = store_data[15:0];
                wstrb = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            f3_sw:   wstrb = '1;
            default: wstrb = '0;  // not a store width
        endcase
    end

endmodule

// File: mem_stage/mem_stage.sv
`timescale 1ns/100ps
// mem_stage
// one-entry buffer between execute and writeback; fires the sram strobe
// for loads and stores and holds a load until its data returns
module mem_stage import isa_pkg::*, mem_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [xlen-1:0]       pc,
    input  logic [xlen-1:0]       inst,
    input  logic [xlen-1:0]       ex_result,
    input  logic [xlen-1:0]       csr_value,
    input  logic [reg_addr_w-1:0] rd,
    input  logic                  reg_we,
    input  logic [csr_we_w-1:0]   csr_we,
    input  logic                  mem_ren,
    input  logic                  mem_wen,
    input  logic [funct3_w-1:0]   funct3,
    input  logic [xlen-1:0]       store_data,
    input  logic                  jump,
    input  logic [xlen-1:0]       rdata,
    input  logic                  rvalid,
    input  logic                  wb_ready,
    output logic                  in_ready,
    output logic                  rd_en,
    output logic                  wr_en,
    output logic [mem_addr_w-1:0] addr,
    output logic [xlen-1:0]       wdata,
    output logic [strb_w-1:0]     wstrb,
    output logic                  wb_valid,
    output logic [xlen-1:0]       wb_pc,
    output logic [xlen-1:0]       wb_inst,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic                  wb_reg_we,
    output logic [csr_we_w-1:0]   wb_csr_we,
    output logic [xlen-1:0]       wb_csr_value,
    output logic [xlen-1:0]       wb_ex_result,
    output logic [xlen-1:0]       wb_load_data,
    output logic                  wb_is_load,
    output logic                  wb_jump
);

    logic [1:0]          state;
    logic                accept;
    logic                drain;
    logic [funct3_w-1:0] funct3_q;
    logic [xlen-1:0]     store_data_q;
    logic [xlen-1:0]     load_aligned;

    assign drain    = (state == st_full) && wb_ready;
    assign in_ready = (state == st_idle) || drain;
    assign accept   = in_valid && in_ready;
    assign wb_valid = (state == st_full);
    assign rd_en    = (state == st_issue);  // one cycle per load
    assign addr     = wb_ex_result[mem_addr_w+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle, st_full: begin
                    if (accept)
                        state <= mem_ren ? st_issue : st_full;
                    else if (drain)
                        state <= st_idle;
                end
                st_issue:     state <= st_wait_read;
                st_wait_read: if (rvalid) state <= st_full;
                default:      state <= st_idle;
            endcase
        end
    end

    // store strobe in the cycle after accept
    always_ff @(posedge clk) begin
        if (!rst_n)
            wr_en <= 1'b0;
        else
            wr_en <= accept && mem_wen && !mem_ren;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb_pc        <= pc;
            wb_inst      <= inst;
            wb_rd        <= rd;
            wb_reg_we    <= reg_we;
            wb_csr_we    <= csr_we;
            wb_csr_value <= csr_value;
            wb_ex_result <= ex_result;
            wb_is_load   <= mem_ren;
            wb_jump      <= jump;
            funct3_q     <= funct3;
            store_data_q <= store_data;
        end
        if (state == st_wait_read && rvalid)
            wb_load_data <= load_aligned;  // aligned read data
    end

    mem_align mem_align_inst (
        .funct3     (funct3_q),
        .byte_off   (wb_ex_result[1:0]),
        .rdata      (rdata),
        .store_data (store_data_q),
        .load_data  (load_aligned),
        .wdata      (wdata),
        .wstrb      (wstrb)
    );

endmodule

// File: rtl/data_sram.sv
`timescale 1ns/100ps
// data_sram
// word-wide data memory with byte strobes and a fixed-latency read pipe
module data_sram import isa_pkg::*, mem_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rd_en,
    input  logic                  wr_en,
    input  logic [mem_addr_w-1:0] addr,
    input  logic [xlen-1:0]       wdata,
    input  logic [strb_w-1:0]     wstrb,
    output logic [xlen-1:0]       rdata,
    output logic                  rvalid
);

    mem_word_u             mem [mem_words];
    mem_word_u             wdata_u;
    logic [sram_latency-1:0] vld_pipe;
    logic [xlen-1:0]       data_pipe [sram_latency];

    assign wdata_u = wdata;
    assign rdata   = data_pipe[sram_latency-1];
    assign rvalid  = vld_pipe[sram_latency-1];

    initial begin
        for (int i = 0; i < mem_words; i++)
            mem[i] = '0;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < strb_w; i++)
                if (wstrb[i])
                    mem[addr].bytes[i] <= wdata_u.bytes[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            vld_pipe <= '0;
        else
            vld_pipe <= {vld_pipe[sram_latency-2:0], rd_en};
    end

    always_ff @(posedge clk) begin
        if (rd_en)
            data_pipe[0] <= mem[addr].word;  // old data on same-cycle write
        for (int i = 1; i < sram_latency; i++)
            data_pipe[i] <= data_pipe[i-1];
    end

endmodule

// File: rtl/wb_stage.sv
`timescale 1ns/100ps
// wb_stage
// picks the register write value and reports each retired instruction
module wb_stage import isa_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wb_valid,
    input  logic [xlen-1:0]       pc,
    input  logic [xlen-1:0]       inst,
    input  logic [reg_addr_w-1:0] rd,
    input  logic                  reg_we,
    input  logic [csr_we_w-1:0]   csr_we,
    input  logic [xlen-1:0]       csr_value,
    input  logic [xlen-1:0]       ex_result,
    input  logic [xlen-1:0]       load_data,
    input  logic                  is_load,
    input  logic                  jump,
    input  logic                  wb_hold,
    output logic                  wb_ready,
    output logic                  rf_we,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic [xlen-1:0]       rf_wdata,
    output logic                  commit,
    output logic [xlen-1:0]       commit_pc
);

    logic            xfer;
    logic [xlen-1:0] link_addr;
    logic [xlen-1:0] wr_value;

    assign wb_ready  = !wb_hold;
    assign xfer      = wb_valid && wb_ready;
    assign link_addr = pc + xlen'(4);  // jump return address

    always_comb begin
        if (jump)
            wr_value = link_addr;
        else if (is_load)
            wr_value = load_data;
        else if (csr_we != '0)
            wr_value = csr_value;  // csr read-back
        else
            wr_value = ex_result;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rf_we  <= 1'b0;
            commit <= 1'b0;
        end else begin
            rf_we  <= xfer && reg_we && (rd != '0);  // x0 never written
            commit <= xfer;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            rf_waddr  <= rd;
            rf_wdata  <= wr_value;
            commit_pc <= pc;
        end
    end

endmodule

// File: rtl/lsu_top.sv
`timescale 1ns/100ps
// lsu_top
// memory stage, data sram and writeback stage wired together
module lsu_top import isa_pkg::*, mem_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [xlen-1:0]       pc,
    input  logic [xlen-1:0]       inst,
    input  logic [xlen-1:0]       ex_result,
    input  logic [xlen-1:0]       csr_value,
    input  logic [reg_addr_w-1:0] rd,
    input  logic                  reg_we,
    input  logic [csr_we_w-1:0]   csr_we,
    input  logic                  mem_ren,
    input  logic                  mem_wen,
    input  logic [funct3_w-1:0]   funct3,
    input  logic [xlen-1:0]       store_data,
    input  logic                  jump,
    output logic                  in_ready,
    input  logic                  wb_hold,
    output logic                  rf_we,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic [xlen-1:0]       rf_wdata,
    output logic                  commit,
    output logic [xlen-1:0]       commit_pc
);

    logic                  rd_en;
    logic                  wr_en;
    logic [mem_addr_w-1:0] addr;
    logic [xlen-1:0]       wdata;
    logic [strb_w-1:0]     wstrb;
    logic [xlen-1:0]       rdata;
    logic                  rvalid;
    logic                  wb_valid;
    logic                  wb_ready;
    logic [xlen-1:0]       wb_pc;
    logic [xlen-1:0]       wb_inst;
    logic [reg_addr_w-1:0] wb_rd;
    logic                  wb_reg_we;
    logic [csr_we_w-1:0]   wb_csr_we;
    logic [xlen-1:0]       wb_csr_value;
    logic [xlen-1:0]       wb_ex_result;
    logic [xlen-1:0]       wb_load_data;
    logic                  wb_is_load;
    logic                  wb_jump;

    mem_stage mem_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .pc           (pc),
        .inst         (inst),
        .ex_result    (ex_result),
        .csr_value    (csr_value),
        .rd           (rd),
        .reg_we       (reg_we),
        .csr_we       (csr_we),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .funct3       (funct3),
        .store_data   (store_data),
        .jump         (jump),
        .rdata        (rdata),
        .rvalid       (rvalid),
        .wb_ready     (wb_ready),
        .in_ready     (in_ready),
        .rd_en        (rd_en),
        .wr_en        (wr_en),
        .addr         (addr),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wb_valid     (wb_valid),
        .wb_pc        (wb_pc),
        .wb_inst      (wb_inst),
        .wb_rd        (wb_rd),
        .wb_reg_we    (wb_reg_we),
        .wb_csr_we    (wb_csr_we),
        .wb_csr_value (wb_csr_value),
        .wb_ex_result (wb_ex_result),
        .wb_load_data (wb_load_data),
        .wb_is_load   (wb_is_load),
        .wb_jump      (wb_jump)
    );

    data_sram data_sram_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd_en  (rd_en),
        .wr_en  (wr_en),
        .addr   (addr),
        .wdata  (wdata),
        .wstrb  (wstrb),
        .rdata  (rdata),
        .rvalid (rvalid)
    );

    wb_stage wb_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_valid  (wb_valid),
        .pc        (wb_pc),
        .inst      (wb_inst),
        .rd        (wb_rd),
        .reg_we    (wb_reg_we),
        .csr_we    (wb_csr_we),
        .csr_value (wb_csr_value),
        .ex_result (wb_ex_result),
        .load_data (wb_load_data),
        .is_load   (wb_is_load),
        .jump      (wb_jump),
        .wb_hold   (wb_hold),
        .wb_ready  (wb_ready),
        .rf_we     (rf_we),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata),
        .commit    (commit),
        .commit_pc (commit_pc)
    );

endmodule

// File: tests/tb_lsu_top.sv
`timescale 1ns/100ps
// tb_lsu_top
// drives lsu_top from a case file, checks writeback values, ordering,
// latency and back-pressure against a reference memory model
module tb_lsu_top import isa_pkg::*, mem_pkg::*; ();

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  in_valid;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       inst;
    logic [xlen-1:0]       ex_result;
    logic [xlen-1:0]       csr_value;
    logic [reg_addr_w-1:0] rd;
    logic                  reg_we;
    logic [csr_we_w-1:0]   csr_we;
    logic                  mem_ren;
    logic                  mem_wen;
    logic [funct3_w-1:0]   funct3;
    logic [xlen-1:0]       store_data;
    logic                  jump;
    logic                  in_ready;
    logic                  wb_hold;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;
    logic                  commit;
    logic [xlen-1:0]       commit_pc;

    // case table in case-file column order
    logic [31:0] c_op [32];
    logic [31:0] c_f3 [32];
    logic [31:0] c_rd [32];
    logic [31:0] c_pc [32];
    logic [31:0] c_val [32];
    logic [31:0] c_sd [32];
    logic [31:0] c_csr [32];
    logic [31:0] c_csrwe [32];
    logic [31:0] c_jump [32];
    logic [31:0] c_exp [32];
    int          ncases = 0;

    logic [xlen-1:0] ref_mem [mem_words];
    logic [31:0]     lcg_state = 32'd86872;
    int              cyc = 0;
    int              checks = 0;
    int              errors = 0;
    int              commits = 0;
    int              seq = 0;
    int              ld_seq = -1;   // last accepted load
    int              ld_done = -1;  // last committed load
    int              ld_acc = 0;
    logic            aborted = 1'b0;

    // one entry per accepted instruction in accept order
    int              q_idx [$];
    int              q_acc [$];
    int              q_seq [$];
    int              q_lat [$];
    logic [xlen-1:0] q_model [$];

    lsu_top lsu_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .pc         (pc),
        .inst       (inst),
        .ex_result  (ex_result),
        .csr_value  (csr_value),
        .rd         (rd),
        .reg_we     (reg_we),
        .csr_we     (csr_we),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .funct3     (funct3),
        .store_data (store_data),
        .jump       (jump),
        .in_ready   (in_ready),
        .wb_hold    (wb_hold),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .commit     (commit),
        .commit_pc  (commit_pc)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected load result from a stored word
    function automatic logic [31:0] load_value(input logic [31:0] word,
                                               input logic [2:0] f3,
                                               input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (f3)
            f3_lb:   return {{24{b[7]}}, b};
            f3_lh:   return {{16{h[15]}}, h};
            f3_lbu:  return {24'd0, b};
            f3_lhu:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    task automatic store_ref(input logic [31:0] a, input logic [2:0] f3,
                             input logic [31:0] data);
        logic [mem_addr_w-1:0] idx;
        logic [1:0]            off;
        idx = a[mem_addr_w+1:2];
        off = a[1:0];
        case (f3)
            f3_sb:   ref_mem[idx][8*off +: 8] = data[7:0];
            f3_sh:   ref_mem[idx][16*off[1] +: 16] = data[15:0];  // bit 0 ignored
            default: ref_mem[idx] = data;
        endcase
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("** Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic next_cycle(input int pass);
        logic [31:0] r;
        @(negedge clk);
        r = rand_next();
        wb_hold = (pass == 1) && (r[9:7] < 3'd3);
    endtask

    task automatic drive_case(input int i);
        in_valid   = 1'b1;
        pc         = c_pc[i];
        inst       = 32'h00000013;  // 32-bit encoding
        ex_result  = c_val[i];
        store_data = c_sd[i];
        csr_value  = c_csr[i];
        csr_we     = c_csrwe[i][3:0];
        jump       = c_jump[i][0];
        funct3     = c_f3[i][2:0];
        rd         = c_rd[i][4:0];
        mem_ren    = (c_op[i] == 32'd1);
        mem_wen    = (c_op[i] == 32'd2);
        reg_we     = (c_op[i] != 32'd2);
    endtask

    task automatic run_pass(input int pass);
        int          gap;
        int          waits;
        int          acc;
        logic [31:0] r;
        logic [31:0] model;
        for (int i = 0; i < ncases; i++) begin
            r = rand_next();
            gap = int'(r[12:11]);
            repeat (gap) begin
                next_cycle(pass);
                in_valid = 1'b0;
            end
            next_cycle(pass);
            drive_case(i);
            #1;
            waits = 0;
            while (!in_ready && waits < 100) begin
                next_cycle(pass);
                #1;
                waits++;
            end
            if (!in_ready) begin
                $display("in_ready stayed low for 100 cycles at case %0d", i);
                aborted = 1'b1;
                return;
            end
            acc = cyc + 1;  // accepted on the coming edge
            model = 32'd0;
            if (c_op[i] == 32'd2)
                store_ref(c_val[i], c_f3[i][2:0], c_sd[i]);
            if (c_op[i] == 32'd1) begin
                model = load_value(ref_mem[c_val[i][mem_addr_w+1:2]], c_f3[i][2:0],
                                   c_val[i][1:0]);
                ld_seq = seq;
                ld_acc = acc;
            end
            q_idx.push_back(i);
            q_acc.push_back(acc);
            q_seq.push_back(seq);
            q_model.push_back(model);
            q_lat.push_back(pass == 1 ? 0 : (c_op[i] == 32'd1 ? 5 : 2));
            seq++;
        end
        next_cycle(pass);
        in_valid = 1'b0;
    endtask

    always @(negedge clk) begin : monitor
        int              idx;
        int              lat;
        int              acc;
        int              sq;
        logic [xlen-1:0] model;
        logic            exp_we;
        #2;
        if (rst_n && commit) begin
            commits++;
            assert (q_idx.size() != 0) else begin
                errors++;
                $display("commit pulse with no instruction outstanding at %0t ns", $time);
            end
            if (q_idx.size() != 0) begin
                idx   = q_idx.pop_front();
                acc   = q_acc.pop_front();
                sq    = q_seq.pop_front();
                lat   = q_lat.pop_front();
                model = q_model.pop_front();
                exp_we = (c_op[idx] != 32'd2) && (c_rd[idx] != 32'd0);
                check_word("commit_pc", c_pc[idx], commit_pc);
                check_word("rf_we", {31'd0, exp_we}, {31'd0, rf_we});
                if (exp_we) begin
                    check_word("rf_waddr", c_rd[idx], {27'd0, rf_waddr});
                    check_word("rf_wdata", c_exp[idx], rf_wdata);
                    if (c_op[idx] == 32'd1)
                        check_word("rf_wdata (memory model)", model, rf_wdata);
                end
                if (lat != 0)
                    check_word("commit latency", lat, cyc + 1 - acc);
                if (sq == ld_seq)
                    ld_done = sq;
            end
        end
        // load in issue or wait, or held at the writeback boundary
        if (ld_seq != ld_done && cyc >= ld_acc && ((cyc - ld_acc) < 3 || wb_hold))
            check_word("in_ready", 32'd0, {31'd0, in_ready});
    end

    initial begin : main
        int    fd;
        int    n;
        int    waits;
        string line;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        pc         = '0;
        inst       = 32'h00000013;
        ex_result  = '0;
        csr_value  = '0;
        rd         = '0;
        reg_we     = 1'b0;
        csr_we     = '0;
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        funct3     = '0;
        store_data = '0;
        jump       = 1'b0;
        wb_hold    = 1'b0;
        for (int i = 0; i < mem_words; i++)
            ref_mem[i] = '0;  // sram starts cleared
        fd = $fopen("tests/lsu_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/lsu_cases.txt");
            aborted = 1'b1;
        end else begin
            while ($fgets(line, fd) != 0 && ncases < 32) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", c_op[ncases],
                            c_f3[ncases], c_rd[ncases], c_pc[ncases], c_val[ncases],
                            c_sd[ncases], c_csr[ncases], c_csrwe[ncases],
                            c_jump[ncases], c_exp[ncases]);
                if (n == 10)
                    ncases++;
            end
            $fclose(fd);
            if (ncases == 0) begin
                $display("no cases found in tests/lsu_cases.txt");
                aborted = 1'b1;
            end
        end

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        #1;
        check_word("in_ready after reset", 32'd1, {31'd0, in_ready});
        check_word("commit after reset", 32'd0, {31'd0, commit});
        check_word("rf_we after reset", 32'd0, {31'd0, rf_we});

        if (!aborted)
            run_pass(0);  // latency checked without back-pressure
        if (!aborted)
            run_pass(1);  // random wb_hold
        waits = 0;
        while (!aborted && q_idx.size() != 0 && waits < 100) begin
            next_cycle(0);
            #3;
            waits++;
        end
        if (!aborted && q_idx.size() != 0) begin
            $display("%0d instructions never committed", q_idx.size());
            aborted = 1'b1;
        end
        if (!aborted) begin
            repeat (4) next_cycle(0);  // window for late or repeated commits
            check_word("commit count", 2 * ncases, commits);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (aborted || errors != 0)
            $display("Regression failed");
        else
            $display("Regression passed");
        $finish;
    end

endmodule

// File: tests/lsu_cases.txt
# op(0 alu, 1 load, 2 store) funct3 rd pc value(addr or alu) store_data csr_value csr_we jump
# expected rf_wdata last; all columns hex
0 0 01 00001000 12345678 00000000 00000000 0 0 12345678
0 0 00 00001004 deadbeef 00000000 00000000 0 0 deadbeef
2 2 00 00001008 00000040 8899aabb 00000000 0 0 00000000
1 2 05 0000100c 00000040 00000000 00000000 0 0 8899aabb
2 0 00 00001010 00000041 123456f0 00000000 0 0 00000000
2 1 00 00001014 00000042 abcd7e11 00000000 0 0 00000000
1 2 06 00001018 00000040 00000000 00000000 0 0 7e11f0bb
1 0 07 0000101c 00000040 00000000 00000000 0 0 ffffffbb
1 0 08 00001020 00000041 00000000 00000000 0 0 fffffff0
1 0 09 00001024 00000042 00000000 00000000 0 0 00000011
1 0 0a 00001028 00000043 00000000 00000000 0 0 0000007e
1 4 0b 0000102c 00000040 00000000 00000000 0 0 000000bb
1 4 0c 00001030 00000041 00000000 00000000 0 0 000000f0
1 1 0d 00001034 00000040 00000000 00000000 0 0 fffff0bb
1 1 0e 00001038 00000042 00000000 00000000 0 0 00007e11
1 5 0f 0000103c 00000040 00000000 00000000 0 0 0000f0bb
1 5 10 00001040 00000042 00000000 00000000 0 0 00007e11
2 1 00 00001044 00000080 0000c3a5 00000000 0 0 00000000
2 0 00 00001048 00000083 00000096 00000000 0 0 00000000
1 2 11 0000104c 00000080 00000000 00000000 0 0 9600c3a5
1 4 12 00001050 00000083 00000000 00000000 0 0 00000096
1 4 13 00001054 00000082 00000000 00000000 0 0 00000000
0 0 14 00001058 00000200 00000000 00000000 0 1 0000105c
0 0 15 0000105c 00000055 00000000 cafe0001 1 0 cafe0001

// File: vlog.f
common/isa_pkg.sv
common/mem_pkg.sv
mem_stage/mem_align.sv
mem_stage/mem_stage.sv
rtl/data_sram.sv
rtl/wb_stage.sv
rtl/lsu_top.sv
tests/tb_lsu_top.sv

// File: Makefile
# Verilator lint and simulation of the lsu testbench

VERILATOR  ?= verilator
FLIST      ?= vlog.f
TB_TOP     ?= tb_lsu_top
RTL_TOP    ?= lsu_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing
PASS_MSG   ?= Regression passed
RTL_SRCS   ?= $(shell grep -v '^tests/' $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
